// ==== Makefile ====
# Verilator build and run of the transmit engine testbench

VERILATOR ?= verilator
TOP       ?= tb_tx_engine
FILELIST  ?= tx_engine_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)
	@! grep -q "TESTBENCH FAILED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tb_clkgen.sv ====
/* testbench clock and synchronous reset source */
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen #(
   parameter int PERIOD       = 100,  // ns
   parameter int RESET_CYCLES = 4
) (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD / 2) clk_o = ~clk_o;
   end

   initial begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #(PERIOD / 10) rst_n_o = 1'b1;  // released off the edge like other inputs
   end

endmodule

`default_nettype wire

// ==== dv/tb_tx_engine.sv ====
/* directed tests for the transmit engine: registers, completions,
   memory write runs in wrap and stop mode, log clear */
`timescale 1ns/1ns
`default_nettype none

module tb_tx_engine;

   localparam int TS_W       = 38;
   localparam int LOG_ADDR_W = 3;
   localparam int LOG_DEPTH  = 1 << LOG_ADDR_W;
   localparam int PERIOD     = 100;
   localparam int DRIVE_DLY  = 10;   // inputs move this long after the edge
   localparam int LEN_DW     = 24;   // three payload beats
   localparam int N_WRAP     = 10;   // runs past the end of the log

   // cycle budget per test, tready idles about a quarter of the time
   localparam int CYC_REGS   = 400;
   localparam int CYC_CPL    = 16 * 30;
   localparam int CYC_WRITES = 2 * N_WRAP * (LEN_DW / 8 + 1) * 8 + 400;
   localparam int WATCHDOG_CYC = CYC_REGS + CYC_CPL + CYC_WRITES + 500;

   logic                  clk;
   logic                  rst_n;
   tx_cfg_pkg::axil_req_t axil_req;
   tx_cfg_pkg::axil_rsp_t axil_rsp;
   tlp_pkg::cpl_req_t     cpl_req;
   logic                  req_compl;
   logic                  compl_done;
   tlp_pkg::cc_beat_t     cc;
   logic                  cc_tvalid;
   logic                  cc_tready;
   tlp_pkg::rq_beat_t     rq;
   logic                  rq_tvalid;
   logic                  rq_tready;
   logic                  bram_we;
   logic [LOG_ADDR_W-1:0] bram_addr;
   logic [TS_W-1:0]       bram_data;

   int errors;
   int checks;
   int n_done;   // compl_done pulses seen
   int n_last;   // finished write tlps seen

   tlp_pkg::rq_beat_t     beat_q[$];   // every accepted request beat
   logic [LOG_ADDR_W-1:0] waddr_q[$];
   logic [TS_W-1:0]       wdata_q[$];

   tb_clkgen #(.PERIOD(PERIOD), .RESET_CYCLES(4)) u_clkgen (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   tx_engine_top #(.TS_W(TS_W), .LOG_ADDR_W(LOG_ADDR_W)) DUT (
      .clk          (clk),
      .rst_n        (rst_n),
      .axil_i       (axil_req),
      .axil_o       (axil_rsp),
      .cpl_req_i    (cpl_req),
      .req_compl_i  (req_compl),
      .compl_done_o (compl_done),
      .cc_o         (cc),
      .cc_tvalid_o  (cc_tvalid),
      .cc_tready_i  (cc_tready),
      .rq_o         (rq),
      .rq_tvalid_o  (rq_tvalid),
      .rq_tready_i  (rq_tready),
      .bram_we_o    (bram_we),
      .bram_addr_o  (bram_addr),
      .bram_data_o  (bram_data)
   );

   // --------------------
   // monitors and tready
   always @(posedge clk) begin
      if (rst_n && rq_tvalid && rq_tready) begin
         beat_q.push_back(rq);
         if (rq.last)
            n_last++;
      end
      if (rst_n && bram_we) begin
         waddr_q.push_back(bram_addr);
         wdata_q.push_back(bram_data);
      end
      if (rst_n && compl_done)
         n_done++;
   end

   always @(posedge clk) begin
      #DRIVE_DLY;
      rq_tready = ($urandom_range(3) != 0);  // ready 3 cycles in 4
   end

   // --------------------
   // helpers
   task automatic check_eq(input string name, input logic [255:0] got,
                           input logic [255:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch %s: got %0h expected %0h", name, got, exp);
      end
   endtask

   task automatic flag_error(input string msg);
      errors++;
      $display("error: %s", msg);
   endtask

   task automatic step();
      @(posedge clk);
      #DRIVE_DLY;
   endtask

   task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
      axil_req.awvalid = 1'b1;
      axil_req.awaddr  = addr;
      axil_req.wvalid  = 1'b1;
      axil_req.wdata   = data;
      axil_req.wstrb   = 4'hF;
      axil_req.bready  = 1'b1;
      do step(); while (!axil_rsp.awready);
      check_eq("wready", axil_rsp.wready, 1'b1);  // rises with awready
      step();  // ready seen at this edge
      axil_req.awvalid = 1'b0;
      axil_req.wvalid  = 1'b0;
      while (!axil_rsp.bvalid) step();
      check_eq("bresp", axil_rsp.bresp, 2'b00);
      step();
      axil_req.bready = 1'b0;
   endtask

   task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
      axil_req.arvalid = 1'b1;
      axil_req.araddr  = addr;
      axil_req.rready  = 1'b1;
      do step(); while (!axil_rsp.arready);
      step();
      axil_req.arvalid = 1'b0;
      while (!axil_rsp.rvalid) step();
      data = axil_rsp.rdata;
      check_eq("rresp", axil_rsp.rresp, 2'b00);
      step();
      axil_req.rready = 1'b0;
   endtask

   task automatic read_expect(input string name, input logic [7:0] addr,
                              input logic [31:0] exp);
      logic [31:0] rd;
      axil_read(addr, rd);
      check_eq(name, rd, exp);
   endtask

   // completion dwords 0..2 plus read data, per the descriptor layout
   function automatic logic [255:0] completion_data(input tlp_pkg::cpl_req_t r);
      logic [255:0] d;
      logic [12:0]  bc;
      logic [1:0]   low;
      d = '0;
      if (r.be[3] && r.be[0])
         bc = 13'd4;
      else if ((r.be[3:2] == 2'b01 && r.be[0]) || (r.be[3] && r.be[1:0] == 2'b10))
         bc = 13'd3;
      else if (r.be == 4'b0011 || r.be == 4'b0110 || r.be == 4'b1100)
         bc = 13'd2;
      else
         bc = 13'd1;
      low = 2'd0;
      for (int i = 3; i >= 0; i--) begin
         if (r.be[i])
            low = 2'(i);  // ends on the lowest enabled byte
      end
      d[6:0]    = {r.addr[6:2], low};
      d[28:16]  = bc;
      d[42:32]  = {1'b0, r.len};
      d[63:48]  = r.rid;
      d[71:64]  = r.tag;
      d[91:89]  = r.tc;
      d[93:92]  = r.attr;
      d[127:96] = r.rd_data;
      return d;
   endfunction

   function automatic logic [255:0] header_data(input logic [31:0] target,
                                                input logic [10:0] len,
                                                input logic [7:0] tag);
      logic [255:0] h;
      h = '0;
      h[31:2]   = target[31:2];
      h[74:64]  = len;
      h[78:75]  = 4'd1;  // memory write
      h[103:96] = tag;
      return h;
   endfunction

   task automatic flush_capture();
      beat_q.delete();
      waddr_q.delete();
      wdata_q.delete();
      n_last = 0;
   endtask

   task automatic start_run(input logic [31:0] target, input logic [10:0] len,
                            input logic role, input logic wrap);
      axil_write(tx_cfg_pkg::REG_TARGET, target);
      axil_write(tx_cfg_pkg::REG_LEN, 32'(len));
      axil_write(tx_cfg_pkg::REG_CTRL, {29'd0, wrap, role, 1'b1});
   endtask

   // drop run, then wait for the last tlp and its log write
   task automatic stop_run(input logic role, input logic wrap);
      axil_write(tx_cfg_pkg::REG_CTRL, {29'd0, wrap, role, 1'b0});
      while (rq_tvalid || waddr_q.size() != n_last) step();
   endtask

   task automatic check_run(input logic [31:0] target, input logic [10:0] len,
                            input logic role);
      int                nb;
      logic [TS_W-1:0]   stamp;
      logic [TS_W-1:0]   prev;
      tlp_pkg::rq_beat_t b;
      nb   = len / 8 + 1;
      prev = '0;
      check_eq("accepted beats", beat_q.size(), n_last * nb);
      check_eq("log writes", waddr_q.size(), n_last);
      if (beat_q.size() != n_last * nb || waddr_q.size() != n_last)
         return;  // framing broken, field checks meaningless
      for (int t = 0; t < n_last; t++) begin
         stamp = beat_q[t * nb + 1].data[TS_W-1:0];
         for (int i = 0; i < nb; i++) begin
            b = beat_q[t * nb + i];
            check_eq("rq.keep", b.keep, 8'hFF);
            check_eq("rq.user", b.user, 60'hFF);  // full first and last be
            check_eq("rq.last", b.last, i == nb - 1);
            if (i == 0)
               check_eq("rq.data header", b.data, header_data(target, len, {7'(t), !role}));
            else
               check_eq("rq.data payload", b.data, 256'(stamp));
         end
         if (t > 0 && stamp <= prev)
            flag_error($sformatf("stamp of tlp %0d did not increase", t));
         check_eq("bram_addr", waddr_q[t], t % LOG_DEPTH);
         check_eq("bram_data", wdata_q[t], stamp);
         prev = stamp;
      end
   endtask

   // --------------------
   // tests
   task automatic test_registers();
      $display("test: register reset values and readback");
      check_eq("cc_tvalid after reset", cc_tvalid, 1'b0);
      check_eq("compl_done after reset", compl_done, 1'b0);
      check_eq("rq_tvalid after reset", rq_tvalid, 1'b0);
      check_eq("bram_we after reset", bram_we, 1'b0);
      check_eq("bvalid after reset", axil_rsp.bvalid, 1'b0);
      check_eq("rvalid after reset", axil_rsp.rvalid, 1'b0);
      read_expect("ctrl", tx_cfg_pkg::REG_CTRL, 32'd0);
      read_expect("target", tx_cfg_pkg::REG_TARGET, 32'd0);
      read_expect("len", tx_cfg_pkg::REG_LEN, 32'd0);
      read_expect("status", tx_cfg_pkg::REG_STATUS, 32'd0);
      read_expect("log addr", tx_cfg_pkg::REG_LOG_ADDR, 32'd0);
      read_expect("unmapped", 8'h14, 32'd0);
      axil_write(tx_cfg_pkg::REG_TARGET, 32'hCAFE_F00F);
      read_expect("target", tx_cfg_pkg::REG_TARGET, 32'hCAFE_F00C);  // low bits dropped
      axil_write(tx_cfg_pkg::REG_LEN, 32'hFFFF_F7A5);
      read_expect("len", tx_cfg_pkg::REG_LEN, 32'h0000_07A5);  // 11 bits kept
   endtask

   task automatic test_completions();
      tlp_pkg::cpl_req_t req;
      logic [255:0]      exp;
      int                done_before;
      $display("test: completions over all byte enables");
      for (int be = 0; be < 16; be++) begin
         req.tc      = 3'($urandom);
         req.attr    = 2'($urandom);
         req.len     = 10'($urandom);
         req.rid     = 16'($urandom);
         req.tag     = 8'($urandom);
         req.be      = 4'(be);
         req.addr    = 11'($urandom);
         req.rd_data = $urandom;
         exp         = completion_data(req);
         done_before = n_done;
         cpl_req     = req;
         req_compl   = 1'b1;
         do step(); while (!compl_done);
         req_compl = 1'b0;
         // beat must hold while tready is low
         repeat ($urandom_range(1, 3)) begin
            check_eq("cc_tvalid", cc_tvalid, 1'b1);
            check_eq("cc.data", cc.data, exp);
            check_eq("cc.keep", cc.keep, 8'h0F);
            check_eq("cc.last", cc.last, 1'b1);
            check_eq("cc.user", cc.user, 33'd0);
            step();
         end
         cc_tready = 1'b1;
         step();
         cc_tready = 1'b0;
         check_eq("cc_tvalid after handshake", cc_tvalid, 1'b0);
         check_eq("compl_done pulses", n_done, done_before + 1);
      end
   endtask

   task automatic test_wrap_run();
      $display("test: write run in wrap mode");
      flush_capture();
      start_run(32'h8000_1237, 11'(LEN_DW), 1'b0, 1'b1);
      while (n_last < N_WRAP) step();  // ninth write wraps to 0
      stop_run(1'b0, 1'b1);
      check_run(32'h8000_1237, 11'(LEN_DW), 1'b0);
      read_expect("status count", tx_cfg_pkg::REG_STATUS, {8'd0, 16'(n_last), 8'd0});
   endtask

   task automatic test_stop_mode();
      $display("test: write run in stop mode after clear");
      axil_write(tx_cfg_pkg::REG_CTRL, 32'h8);
      flush_capture();  // tags restart at 0 after the clear
      start_run(32'h0004_0100, 11'(LEN_DW), 1'b1, 1'b0);
      while (waddr_q.size() < LOG_DEPTH) step();
      repeat (4 * (LEN_DW / 8 + 1) + 10) step();  // room for a header that must not come
      check_eq("tlps in stop mode", n_last, LOG_DEPTH);
      read_expect("status full", tx_cfg_pkg::REG_STATUS,
                  {8'd0, 16'(LOG_DEPTH), 7'd0, 1'b1});
      read_expect("log addr full", tx_cfg_pkg::REG_LOG_ADDR, 32'(LOG_DEPTH - 1));
      stop_run(1'b1, 1'b0);
      check_run(32'h0004_0100, 11'(LEN_DW), 1'b1);
   endtask

   task automatic test_clear();
      $display("test: clear of log and status");
      axil_write(tx_cfg_pkg::REG_CTRL, 32'h8);
      read_expect("log addr after clear", tx_cfg_pkg::REG_LOG_ADDR, 32'd0);
      read_expect("status after clear", tx_cfg_pkg::REG_STATUS, 32'd0);
      read_expect("ctrl after clear", tx_cfg_pkg::REG_CTRL, 32'd0);  // clear bit reads 0
   endtask

   // --------------------
   // sequence and verdict
   initial begin
      errors      = 0;
      checks      = 0;
      n_done      = 0;
      n_last      = 0;
      axil_req    = '0;
      cpl_req     = '0;
      req_compl   = 1'b0;
      cc_tready   = 1'b0;
      rq_tready   = 1'b0;
      void'($urandom(19542));
      wait (rst_n === 1'b1);
      step();
      test_registers();
      test_completions();
      test_wrap_run();
      test_stop_mode();
      test_clear();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin
      #(WATCHDOG_CYC * PERIOD);
      $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYC);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== hw/cpl_builder.sv ====
/* completer completion path, single beat 3-DW descriptor
   byte count and lower address from the request byte enables */
`timescale 1ns/1ns
`default_nettype none

module cpl_builder (
   input  logic               clk,
   input  logic               rst_n,
   input  tlp_pkg::cpl_req_t  cpl_req_i,
   input  logic               req_compl_i,
   output logic               compl_done_o,
   output tlp_pkg::cc_beat_t  cc_o,
   output logic               cc_tvalid_o,
   input  logic               cc_tready_i
);

   logic         req_compl_q;
   logic         start;
   logic [12:0]  byte_count;
   logic [1:0]   lo_bits;       // index of lowest enabled byte
   logic [6:0]   lower_addr;
   logic [127:0] desc;

   assign start = req_compl_q && !cc_tvalid_o;  // one completion in flight

   always_comb begin
      casez (cpl_req_i.be)
         4'b1??1:                   byte_count = 13'd4;
         4'b01?1, 4'b1?10:          byte_count = 13'd3;
         4'b0011, 4'b0110, 4'b1100: byte_count = 13'd2;
         default:                   byte_count = 13'd1;  // single byte or none
      endcase
   end

   always_comb begin
      casez (cpl_req_i.be)
         4'b???1: lo_bits = 2'd0;
         4'b??10: lo_bits = 2'd1;
         4'b?100: lo_bits = 2'd2;
         4'b1000: lo_bits = 2'd3;
         default: lo_bits = 2'd0;
      endcase
   end

   assign lower_addr = {cpl_req_i.addr[6:2], lo_bits};

   // descriptor dwords 0..2 and the read data in dword 3
   assign desc = {cpl_req_i.rd_data,
                  2'b00, cpl_req_i.attr, cpl_req_i.tc, 1'b0,
                  16'd0,                        // completer id
                  cpl_req_i.tag, cpl_req_i.rid,
                  2'b00, 3'b000,                // status success
                  1'b0, cpl_req_i.len,          // dword count
                  3'b000, byte_count,
                  9'd0, lower_addr};

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         req_compl_q  <= 1'b0;
         cc_tvalid_o  <= 1'b0;
         compl_done_o <= 1'b0;
      end else begin
         req_compl_q  <= req_compl_i;
         compl_done_o <= start;
         if (start) begin
            cc_tvalid_o <= 1'b1;
         end else if (cc_tready_i) begin
            cc_tvalid_o <= 1'b0;  // drop after the handshake
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         cc_o.data <= {{(tlp_pkg::DATA_W-128){1'b0}}, desc};
         cc_o.keep <= 8'h0F;  // 4 dwords
         cc_o.last <= 1'b1;
         cc_o.user <= 33'd0;
      end
   end

   a_cc_stable: assert property (@(posedge clk) disable iff (!rst_n)
      cc_tvalid_o && !cc_tready_i |=> cc_tvalid_o && $stable(cc_o))
      else $error("completion beat changed under back-pressure");

endmodule

`default_nettype wire

// ==== hw/mwr_requester.sv ====
/* memory write generator, one header beat then len/8 payload beats
   payload carries the stamp taken at the header handshake */
`timescale 1ns/1ns
`default_nettype none

module mwr_requester #(
   parameter int TS_W = 38
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  tx_cfg_pkg::tx_cfg_t  cfg_i,
   input  logic                 stopped_i,
   input  logic [TS_W-1:0]      stamp_i,
   output tlp_pkg::rq_beat_t    rq_o,
   output logic                 rq_tvalid_o,
   input  logic                 rq_tready_i,
   output logic                 tlp_done_o,
   output logic [15:0]          tlp_count_o,
   output logic [TS_W-1:0]      tlp_stamp_o
);

   localparam int PAD_W = tlp_pkg::DATA_W - TS_W;

   logic                       start;
   logic                       hs;
   logic                       in_hdr;     // header is the current beat
   logic [7:0]                 pay_left;   // payload beats not yet presented
   logic [7:0]                 pay_beats;
   logic [7:0]                 tag;
   logic [TS_W-1:0]            stamp_q;
   logic [tlp_pkg::DATA_W-1:0] hdr;

   // idle, previous tlp_done gone, logger not full
   assign start     = cfg_i.run && !stopped_i && !rq_tvalid_o && !tlp_done_o;
   assign hs        = rq_tvalid_o && rq_tready_i;
   assign pay_beats = 8'(cfg_i.len_dw / tlp_pkg::DW_PER_BEAT);
   assign tag       = {tlp_count_o[6:0], !cfg_i.role_receiver};
   assign tlp_stamp_o = stamp_q;

   assign hdr = {{(tlp_pkg::DATA_W-104){1'b0}},
                 tag,
                 16'd0,                 // requester id
                 1'b0, tlp_pkg::REQ_MEM_WR,
                 cfg_i.len_dw,
                 32'd0,                 // upper address
                 cfg_i.target_addr[31:2], 2'b00};

   // --------------------
   // control
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rq_tvalid_o <= 1'b0;
         in_hdr      <= 1'b0;
         pay_left    <= 8'd0;
         tlp_done_o  <= 1'b0;
         tlp_count_o <= 16'd0;
      end else begin
         tlp_done_o <= hs && rq_o.last;
         if (start) begin
            rq_tvalid_o <= 1'b1;
            in_hdr      <= 1'b1;
            pay_left    <= pay_beats;
         end else if (hs) begin
            in_hdr <= 1'b0;
            if (rq_o.last)
               rq_tvalid_o <= 1'b0;
            else
               pay_left <= pay_left - 8'd1;
         end
         if (cfg_i.clear) begin
            tlp_count_o <= 16'd0;
         end else if (hs && rq_o.last) begin
            tlp_count_o <= tlp_count_o + 16'd1;  // low 7 bits give the tag sequence
         end
      end
   end

   // --------------------
   // beat contents
   always_ff @(posedge clk) begin
      if (start) begin
         rq_o.data <= hdr;
         rq_o.keep <= 8'hFF;
         rq_o.last <= (pay_beats == 8'd0);
         rq_o.user <= {52'd0, tlp_pkg::BE_FULL, tlp_pkg::BE_FULL};
      end else if (hs && !rq_o.last) begin
         rq_o.last <= (pay_left == 8'd1);
         if (in_hdr)
            rq_o.data <= {{PAD_W{1'b0}}, stamp_i};  // held for every payload beat
      end
      if (hs && in_hdr)
         stamp_q <= stamp_i;
   end

   a_rq_stable: assert property (@(posedge clk) disable iff (!rst_n)
      rq_tvalid_o && !rq_tready_i |=> rq_tvalid_o && $stable(rq_o))
      else $error("request beat changed under back-pressure");

endmodule

`default_nettype wire

// ==== hw/stamp_logger.sv ====
/* free running timestamp and the bram log write port, wrap or stop mode */
`timescale 1ns/1ns
`default_nettype none

module stamp_logger #(
   parameter int TS_W       = 38,
   parameter int LOG_ADDR_W = 13
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  tx_cfg_pkg::tx_cfg_t    cfg_i,
   input  logic                   tlp_done_i,
   input  logic [TS_W-1:0]        tlp_stamp_i,
   output logic [TS_W-1:0]        stamp_o,
   output logic                   stopped_o,
   output logic [LOG_ADDR_W-1:0]  log_addr_o,
   output logic                   bram_we_o,
   output logic [LOG_ADDR_W-1:0]  bram_addr_o,
   output logic [TS_W-1:0]        bram_data_o
);

   logic write;

   assign write = tlp_done_i && !stopped_o && !cfg_i.clear;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         stamp_o    <= '0;
         stopped_o  <= 1'b0;
         log_addr_o <= '0;
         bram_we_o  <= 1'b0;
      end else begin
         bram_we_o <= write;
         if (cfg_i.clear) begin
            stamp_o    <= '0;
            stopped_o  <= 1'b0;
            log_addr_o <= '0;
         end else begin
            if (cfg_i.run)
               stamp_o <= stamp_o + 1'b1;
            if (write) begin
               if (log_addr_o == {LOG_ADDR_W{1'b1}}) begin
                  if (cfg_i.wrap_mode)
                     log_addr_o <= '0;
                  else
                     stopped_o <= 1'b1;  // last entry written, hold here
               end else begin
                  log_addr_o <= log_addr_o + 1'b1;
               end
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (write) begin
         bram_addr_o <= log_addr_o;
         bram_data_o <= tlp_stamp_i;
      end
   end

   // requester must not finish another tlp once full
   a_no_write_stopped: assert property (@(posedge clk) disable iff (!rst_n)
      stopped_o |-> !tlp_done_i)
      else $error("tlp finished while log stopped");

endmodule

`default_nettype wire

// ==== hw/tlp_pkg.sv ====
/* tlp field widths and encodings, plus the beat structs
   for the requester and completer streams */
`default_nettype none

package tlp_pkg;

   // --------------------
   // widths and constants
   localparam int DATA_W      = 256;  // stream data width
   localparam int DW_PER_BEAT = 8;    // dwords carried per beat

   localparam logic [3:0] REQ_MEM_WR = 4'd1;  // memory write request type
   localparam logic [3:0] BE_FULL    = 4'hF;  // all four bytes, first and last BE

   typedef logic [7:0]  keep_t;    // one bit per dword
   typedef logic [10:0] len_dw_t;  // dword count

   // --------------------
   // stream beats
   typedef struct packed {
      logic [DATA_W-1:0] data;
      keep_t             keep;
      logic              last;
      logic [59:0]       user;   // [3:0] first be, [7:4] last be
   } rq_beat_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      keep_t             keep;
      logic              last;
      logic [32:0]       user;   // unused, zero
   } cc_beat_t;

   // pending completer read, as decoded from the request side
   typedef struct packed {
      logic [2:0]  tc;
      logic [1:0]  attr;
      logic [9:0]  len;
      logic [15:0] rid;
      logic [7:0]  tag;
      logic [3:0]  be;
      logic [10:0] addr;
      logic [31:0] rd_data;
   } cpl_req_t;

endpackage

`default_nettype wire

// ==== hw/tx_cfg_pkg.sv ====
/* axi4-lite bundles, register map offsets and the engine configuration */
`default_nettype none

package tx_cfg_pkg;

   typedef struct packed {
      logic        awvalid;
      logic [7:0]  awaddr;
      logic        wvalid;
      logic [31:0] wdata;
      logic [3:0]  wstrb;
      logic        bready;
      logic        arvalid;
      logic [7:0]  araddr;
      logic        rready;
   } axil_req_t;

   typedef struct packed {
      logic        awready;
      logic        wready;
      logic        bvalid;
      logic [1:0]  bresp;
      logic        arready;
      logic        rvalid;
      logic [31:0] rdata;
      logic [1:0]  rresp;
   } axil_rsp_t;

   typedef struct packed {
      logic              run;
      logic              role_receiver;
      logic              wrap_mode;
      logic              clear;        // single cycle
      logic [31:0]       target_addr;
      tlp_pkg::len_dw_t  len_dw;
   } tx_cfg_t;

   // --------------------
   // register map
   localparam logic [7:0] REG_CTRL     = 8'h00;
   localparam logic [7:0] REG_TARGET   = 8'h04;
   localparam logic [7:0] REG_LEN      = 8'h08;
   localparam logic [7:0] REG_STATUS   = 8'h0C;
   localparam logic [7:0] REG_LOG_ADDR = 8'h10;

endpackage

`default_nettype wire

// ==== hw/tx_csr.sv ====
/* axi4-lite register block for the transmit engine
   control, target address and length registers with status readback */
`timescale 1ns/1ns
`default_nettype none

module tx_csr #(
   parameter int LOG_ADDR_W = 13
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  tx_cfg_pkg::axil_req_t  axil_i,
   output tx_cfg_pkg::axil_rsp_t  axil_o,
   output tx_cfg_pkg::tx_cfg_t    cfg_o,
   input  logic                   stopped_i,
   input  logic [LOG_ADDR_W-1:0]  log_addr_i,
   input  logic [15:0]            tlp_count_i
);

   logic        wr_ack;     // awready / wready pulse
   logic        rd_ack;     // arready pulse
   logic        bvalid_q;
   logic        rvalid_q;
   logic [31:0] rdata_q;
   logic [31:0] rd_mux;

   logic        run_q;
   logic        role_q;
   logic        wrap_q;
   logic        clear_q;
   logic [31:0] target_q;
   logic [10:0] len_q;

   // --------------------
   // write channel
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ack   <= 1'b0;
         bvalid_q <= 1'b0;
         clear_q  <= 1'b0;
         run_q    <= 1'b0;
         role_q   <= 1'b0;
         wrap_q   <= 1'b0;
         target_q <= 32'd0;
         len_q    <= 11'd0;
      end else begin
         wr_ack  <= axil_i.awvalid && axil_i.wvalid && !wr_ack && !bvalid_q;
         clear_q <= 1'b0;  // pulse only
         if (wr_ack) begin
            bvalid_q <= 1'b1;
         end else if (axil_i.bready) begin
            bvalid_q <= 1'b0;
         end
         if (wr_ack && axil_i.wstrb[0] && axil_i.awaddr == tx_cfg_pkg::REG_CTRL) begin
            run_q   <= axil_i.wdata[0];
            role_q  <= axil_i.wdata[1];
            wrap_q  <= axil_i.wdata[2];
            clear_q <= axil_i.wdata[3];
         end
         if (wr_ack && axil_i.awaddr == tx_cfg_pkg::REG_TARGET) begin
            for (int b = 0; b < 4; b++) begin
               if (axil_i.wstrb[b])
                  target_q[8*b +: 8] <= axil_i.wdata[8*b +: 8];
            end
            target_q[1:0] <= 2'b00;  // dword aligned
         end
         if (wr_ack && axil_i.awaddr == tx_cfg_pkg::REG_LEN) begin
            if (axil_i.wstrb[0])
               len_q[7:0] <= axil_i.wdata[7:0];
            if (axil_i.wstrb[1])
               len_q[10:8] <= axil_i.wdata[10:8];
         end
      end
   end

   // --------------------
   // read channel
   always_comb begin
      case (axil_i.araddr)
         tx_cfg_pkg::REG_CTRL:     rd_mux = {29'd0, wrap_q, role_q, run_q};  // clear reads 0
         tx_cfg_pkg::REG_TARGET:   rd_mux = target_q;
         tx_cfg_pkg::REG_LEN:      rd_mux = {21'd0, len_q};
         tx_cfg_pkg::REG_STATUS:   rd_mux = {8'd0, tlp_count_i, 7'd0, stopped_i};
         tx_cfg_pkg::REG_LOG_ADDR: rd_mux = 32'(log_addr_i);
         default:                  rd_mux = 32'd0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_ack   <= 1'b0;
         rvalid_q <= 1'b0;
      end else begin
         rd_ack <= axil_i.arvalid && !rd_ack && !rvalid_q;
         if (rd_ack) begin
            rvalid_q <= 1'b1;
         end else if (axil_i.rready) begin
            rvalid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rd_ack)
         rdata_q <= rd_mux;  // sampled while araddr still held
   end

   always_comb begin
      axil_o.awready = wr_ack;
      axil_o.wready  = wr_ack;
      axil_o.bvalid  = bvalid_q;
      axil_o.bresp   = 2'b00;    // OKAY
      axil_o.arready = rd_ack;
      axil_o.rvalid  = rvalid_q;
      axil_o.rdata   = rdata_q;
      axil_o.rresp   = 2'b00;
   end

   always_comb begin
      cfg_o.run           = run_q;
      cfg_o.role_receiver = role_q;
      cfg_o.wrap_mode     = wrap_q;
      cfg_o.clear         = clear_q;
      cfg_o.target_addr   = target_q;
      cfg_o.len_dw        = len_q;
   end

   // write response must wait for the master
   a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
      axil_o.bvalid && !axil_i.bready |=> axil_o.bvalid)
      else $error("bvalid dropped before bready");

endmodule

`default_nettype wire

// ==== hw/tx_engine_top.sv ====
/* transmit engine top, register block, completion builder,
   memory write requester and stamp logger */
`timescale 1ns/1ns
`default_nettype none

module tx_engine_top #(
   parameter int TS_W       = 38,
   parameter int LOG_ADDR_W = 13
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  tx_cfg_pkg::axil_req_t  axil_i,
   output tx_cfg_pkg::axil_rsp_t  axil_o,
   input  tlp_pkg::cpl_req_t      cpl_req_i,
   input  logic                   req_compl_i,
   output logic                   compl_done_o,
   output tlp_pkg::cc_beat_t      cc_o,
   output logic                   cc_tvalid_o,
   input  logic                   cc_tready_i,
   output tlp_pkg::rq_beat_t      rq_o,
   output logic                   rq_tvalid_o,
   input  logic                   rq_tready_i,
   output logic                   bram_we_o,
   output logic [LOG_ADDR_W-1:0]  bram_addr_o,
   output logic [TS_W-1:0]        bram_data_o
);

   tx_cfg_pkg::tx_cfg_t   cfg;
   logic                  stopped;
   logic [LOG_ADDR_W-1:0] log_addr;
   logic [15:0]           tlp_count;
   logic                  tlp_done;
   logic [TS_W-1:0]       stamp;       // running counter
   logic [TS_W-1:0]       tlp_stamp;   // stamp of the last header sent

   tx_csr #(.LOG_ADDR_W(LOG_ADDR_W)) u_csr (
      .clk         (clk),
      .rst_n       (rst_n),
      .axil_i      (axil_i),
      .axil_o      (axil_o),
      .cfg_o       (cfg),
      .stopped_i   (stopped),
      .log_addr_i  (log_addr),
      .tlp_count_i (tlp_count)
   );

   cpl_builder u_cpl (
      .clk          (clk),
      .rst_n        (rst_n),
      .cpl_req_i    (cpl_req_i),
      .req_compl_i  (req_compl_i),
      .compl_done_o (compl_done_o),
      .cc_o         (cc_o),
      .cc_tvalid_o  (cc_tvalid_o),
      .cc_tready_i  (cc_tready_i)
   );

   mwr_requester #(.TS_W(TS_W)) u_mwr (
      .clk         (clk),
      .rst_n       (rst_n),
      .cfg_i       (cfg),
      .stopped_i   (stopped),
      .stamp_i     (stamp),
      .rq_o        (rq_o),
      .rq_tvalid_o (rq_tvalid_o),
      .rq_tready_i (rq_tready_i),
      .tlp_done_o  (tlp_done),
      .tlp_count_o (tlp_count),
      .tlp_stamp_o (tlp_stamp)
   );

   stamp_logger #(.TS_W(TS_W), .LOG_ADDR_W(LOG_ADDR_W)) u_log (
      .clk         (clk),
      .rst_n       (rst_n),
      .cfg_i       (cfg),
      .tlp_done_i  (tlp_done),
      .tlp_stamp_i (tlp_stamp),
      .stamp_o     (stamp),
      .stopped_o   (stopped),
      .log_addr_o  (log_addr),
      .bram_we_o   (bram_we_o),
      .bram_addr_o (bram_addr_o),
      .bram_data_o (bram_data_o)
   );

endmodule

`default_nettype wire

// ==== tx_engine_top.f ====
hw/tlp_pkg.sv
hw/tx_cfg_pkg.sv
hw/tx_csr.sv
hw/cpl_builder.sv
hw/mwr_requester.sv
hw/stamp_logger.sv
hw/tx_engine_top.sv
dv/tb_clkgen.sv
dv/tb_tx_engine.sv
